// ==== source/conan_cfg.svh ====
`ifndef CONAN_CFG_SVH
`define CONAN_CFG_SVH

// ---------------------------------------------------------------------------
// time base
// ---------------------------------------------------------------------------
`define CONAN_SYSTIME_BITS 64
`define CONAN_LATCH_BITS 56
`define CONAN_NLEDS 8
`define CONAN_LED_WRAP_BITS 22
`define CONAN_ROLLOVER_BITS 26

// ---------------------------------------------------------------------------
// acquisition messages
// ---------------------------------------------------------------------------
`define CONAN_DAQ_BITS 32
`define CONAN_DAQT_SYSTIME_SET 8'd32
`define CONAN_DAQT_SYSTIME_ROLLOVER 8'd33

`endif

// ==== source/conan_pkg.sv ====
`default_nettype none

`include "conan_cfg.svh"

package conan_pkg;

	// first word of a time message
	typedef struct packed {
		logic [7:0] daq_type;
		logic [23:0] stamp_hi;
	} daq_header_t;

	// header view for the first word, raw view for the rest
	typedef union packed {
		daq_header_t hdr;
		logic [`CONAN_DAQ_BITS-1:0] raw;
	} daq_word_u;

	typedef enum logic [1:0] {
		sy_idle,
		sy_wait_grant,
		sy_send_lower
	} sy_state_e;

endpackage

`default_nettype wire

// ==== source/daq_if.sv ====
`timescale 1ns/1ns
`default_nettype none

// one acquisition message stream, granted by the arbiter
interface daq_if;
	conan_pkg::daq_word_u data;
	logic valid;
	logic end_msg;
	logic req;
	logic grant;

	modport source (
		output data, valid, end_msg, req,
		input grant
	);

	modport sink (
		input data, valid, end_msg, req,
		output grant
	);
endinterface

`default_nettype wire

// ==== source/time_base.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "conan_cfg.svh"

module time_base (
	input logic clk,
	input logic arst_n,
	input logic [`CONAN_SYSTIME_BITS-1:0] systime_set,
	input logic systime_set_en,
	output logic [`CONAN_SYSTIME_BITS-1:0] systime
);

	// free running, a load takes precedence over the increment
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			systime <= '0;
		end else if (systime_set_en) begin
			systime <= systime_set;
		end else begin
			systime <= systime + 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== source/led_chaser.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "conan_cfg.svh"

module led_chaser (
	input logic clk,
	input logic arst_n,
	input logic [`CONAN_SYSTIME_BITS-1:0] systime,
	output logic [`CONAN_NLEDS-1:0] leds
);

	logic wrap;

	assign wrap = (systime[`CONAN_LED_WRAP_BITS-1:0] == '0);

	// one-hot heartbeat, steps left once per wrap of the low bits
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			leds <= `CONAN_NLEDS'(1);
		end else if (wrap) begin
			leds <= {leds[`CONAN_NLEDS-2:0], leds[`CONAN_NLEDS-1]};
		end
	end

endmodule

`default_nettype wire

// ==== source/systime_notifier.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "conan_cfg.svh"

module systime_notifier (
	input logic clk,
	input logic arst_n,
	input logic [`CONAN_SYSTIME_BITS-1:0] systime,
	input logic systime_set_en,
	daq_if.source daq
);

	conan_pkg::sy_state_e sy_state;
	logic trigger;
	logic pending;
	logic pending_set;
	logic msg_set;
	logic [`CONAN_LATCH_BITS-1:0] latched;

	// a load, or the last cycle before the low bits roll over
	assign trigger = systime_set_en || (&systime[`CONAN_ROLLOVER_BITS-1:0]);

	// ------------------------------------------------------------------------
	// handshake FSM
	// ------------------------------------------------------------------------
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			sy_state <= conan_pkg::sy_idle;
			pending <= 1'b0;
			pending_set <= 1'b0;
			daq.req <= 1'b0;
			daq.valid <= 1'b0;
			daq.end_msg <= 1'b0;
		end else begin
			daq.valid <= 1'b0;
			daq.end_msg <= 1'b0;
			case (sy_state)
				conan_pkg::sy_idle: begin
					if (pending) begin
						daq.req <= 1'b1;
						pending <= 1'b0;
						sy_state <= conan_pkg::sy_wait_grant;
					end
				end
				conan_pkg::sy_wait_grant: begin
					if (daq.grant) begin
						daq.req <= 1'b0;
						daq.valid <= 1'b1;
						sy_state <= conan_pkg::sy_send_lower;
					end
				end
				conan_pkg::sy_send_lower: begin
					daq.valid <= 1'b1;
					daq.end_msg <= 1'b1;
					sy_state <= conan_pkg::sy_idle;
				end
				default: sy_state <= conan_pkg::sy_idle;
			endcase
			// a new event overrides the clear in sy_idle
			if (trigger) begin
				pending <= 1'b1;
				pending_set <= systime_set_en;
			end
		end
	end

	// ------------------------------------------------------------------------
	// message payload
	// ------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (sy_state == conan_pkg::sy_idle && pending) begin
			latched <= systime[`CONAN_LATCH_BITS-1:0];
			msg_set <= pending_set;
		end
		if (sy_state == conan_pkg::sy_wait_grant && daq.grant) begin
			daq.data.hdr.daq_type <= msg_set ? `CONAN_DAQT_SYSTIME_SET
				: `CONAN_DAQT_SYSTIME_ROLLOVER;
			daq.data.hdr.stamp_hi <= latched[`CONAN_LATCH_BITS-1:`CONAN_DAQ_BITS];
		end else if (sy_state == conan_pkg::sy_send_lower) begin
			daq.data.raw <= latched[`CONAN_DAQ_BITS-1:0];
		end
	end

endmodule

`default_nettype wire

// ==== source/daq_arbiter.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "conan_cfg.svh"

module daq_arbiter (
	input logic clk,
	input logic arst_n,
	daq_if.sink syst_daq,
	daq_if.sink mcu_daq,
	output logic [`CONAN_DAQ_BITS-1:0] daq_data,
	output logic daq_valid,
	output logic daq_end
);

	localparam logic [1:0] own_none = 2'd0;
	localparam logic [1:0] own_syst = 2'd1;
	localparam logic [1:0] own_mcu = 2'd2;

	logic [1:0] owner;
	logic sel_valid;
	logic sel_end;
	logic [`CONAN_DAQ_BITS-1:0] sel_data;

	// words of the current owner
	always_comb begin
		sel_valid = 1'b0;
		sel_end = 1'b0;
		sel_data = syst_daq.data.raw;
		case (owner)
			own_syst: begin
				sel_valid = syst_daq.valid;
				sel_end = syst_daq.end_msg;
			end
			own_mcu: begin
				sel_valid = mcu_daq.valid;
				sel_end = mcu_daq.end_msg;
				sel_data = mcu_daq.data.raw;
			end
			default: ;
		endcase
	end

	// ------------------------------------------------------------------------
	// ownership and grant
	// ------------------------------------------------------------------------
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			owner <= own_none;
			syst_daq.grant <= 1'b0;
			mcu_daq.grant <= 1'b0;
			daq_valid <= 1'b0;
			daq_end <= 1'b0;
		end else begin
			syst_daq.grant <= 1'b0;
			mcu_daq.grant <= 1'b0;
			daq_valid <= sel_valid;
			daq_end <= sel_valid && sel_end;
			if (owner == own_none) begin
				// time messages first
				if (syst_daq.req) begin
					syst_daq.grant <= 1'b1;
					owner <= own_syst;
				end else if (mcu_daq.req) begin
					mcu_daq.grant <= 1'b1;
					owner <= own_mcu;
				end
			end else if (sel_valid && sel_end) begin
				owner <= own_none;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (sel_valid) begin
			daq_data <= sel_data;
		end
	end

endmodule

`default_nettype wire

// ==== source/conan_top.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "conan_cfg.svh"

module conan_top (
	input logic clk,
	input logic arst_n,
	input logic systime_set_en,
	input logic [`CONAN_SYSTIME_BITS-1:0] systime_set,
	input logic [`CONAN_DAQ_BITS-1:0] mcu_daq_data,
	input logic mcu_daq_valid,
	input logic mcu_daq_end,
	input logic mcu_daq_req,
	output logic mcu_daq_grant,
	output logic [`CONAN_DAQ_BITS-1:0] daq_data,
	output logic daq_valid,
	output logic daq_end,
	output logic [`CONAN_SYSTIME_BITS-1:0] systime,
	output logic [`CONAN_NLEDS-1:0] leds
);

	daq_if syst_daq ();
	daq_if mcu_daq ();

	// mcu side enters as plain pins
	assign mcu_daq.data = mcu_daq_data;
	assign mcu_daq.valid = mcu_daq_valid;
	assign mcu_daq.end_msg = mcu_daq_end;
	assign mcu_daq.req = mcu_daq_req;
	assign mcu_daq_grant = mcu_daq.grant;

	time_base u_time_base (
		.clk(clk),
		.arst_n(arst_n),
		.systime_set(systime_set),
		.systime_set_en(systime_set_en),
		.systime(systime)
	);

	led_chaser u_led_chaser (
		.clk(clk),
		.arst_n(arst_n),
		.systime(systime),
		.leds(leds)
	);

	systime_notifier u_systime_notifier (
		.clk(clk),
		.arst_n(arst_n),
		.systime(systime),
		.systime_set_en(systime_set_en),
		.daq(syst_daq)
	);

	daq_arbiter u_daq_arbiter (
		.clk(clk),
		.arst_n(arst_n),
		.syst_daq(syst_daq),
		.mcu_daq(mcu_daq),
		.daq_data(daq_data),
		.daq_valid(daq_valid),
		.daq_end(daq_end)
	);

endmodule

`default_nettype wire

// ==== bench/tb_clk_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen (
	output logic clk,
	output logic arst_n
);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// reset held over the first three rising edges
	initial begin
		arst_n = 1'b0;
		repeat (3) @(posedge clk);
		arst_n <= 1'b1;
	end

endmodule

`default_nettype wire

// ==== bench/conan_asserts.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "conan_cfg.svh"

module conan_asserts (
	input logic clk,
	input logic arst_n,
	input logic syst_req,
	input logic syst_grant,
	input logic syst_valid,
	input logic mcu_req,
	input logic mcu_grant,
	input logic mcu_valid,
	input logic [1:0] owner,
	input conan_pkg::sy_state_e sy_state,
	input logic [`CONAN_NLEDS-1:0] leds
);

	int fail_count = 0;

	// ------------------------------------------------------------------------
	// handshake
	// ------------------------------------------------------------------------
	// the notifier sits in sy_wait_grant for as long as it requests
	syst_req_held: assert property (@(posedge clk) disable iff (!arst_n)
		syst_req && !syst_grant |=> syst_req && sy_state == conan_pkg::sy_wait_grant)
	else begin
		fail_count++;
		$error("time request dropped before its grant");
	end

	mcu_req_held: assert property (@(posedge clk) disable iff (!arst_n)
		mcu_req && !mcu_grant |=> mcu_req)
	else begin
		fail_count++;
		$error("mcu request dropped before its grant");
	end

	grant_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
		!(syst_grant && mcu_grant))
	else begin
		fail_count++;
		$error("both sources granted in the same cycle");
	end

	// a source sends words only while it owns the output
	syst_valid_owned: assert property (@(posedge clk) disable iff (!arst_n)
		syst_valid |-> owner == 2'd1)
	else begin
		fail_count++;
		$error("time word sent while the notifier does not own the output");
	end

	mcu_valid_owned: assert property (@(posedge clk) disable iff (!arst_n)
		mcu_valid |-> owner == 2'd2)
	else begin
		fail_count++;
		$error("mcu word sent while the mcu does not own the output");
	end

	leds_one_hot: assert property (@(posedge clk) disable iff (!arst_n)
		$onehot(leds))
	else begin
		fail_count++;
		$error("leds are not one-hot");
	end

endmodule

`default_nettype wire

// ==== bench/tb_conan.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "conan_cfg.svh"

module tb_conan;

	logic clk;
	logic arst_n;
	logic systime_set_en;
	logic [`CONAN_SYSTIME_BITS-1:0] systime_set;
	logic [`CONAN_DAQ_BITS-1:0] mcu_daq_data;
	logic mcu_daq_valid;
	logic mcu_daq_end;
	logic mcu_daq_req;
	logic mcu_daq_grant;
	logic [`CONAN_DAQ_BITS-1:0] daq_data;
	logic daq_valid;
	logic daq_end;
	logic [`CONAN_SYSTIME_BITS-1:0] systime;
	logic [`CONAN_NLEDS-1:0] leds;

	logic [31:0] rng;
	int err_count = 0;
	int check_count = 0;
	int rot_count;
	string test_name;
	logic [`CONAN_DAQ_BITS-1:0] exp_words[$];
	logic exp_ends[$];

	tb_clk_gen u_clk_gen (
		.clk(clk),
		.arst_n(arst_n)
	);

	conan_top dut (
		.clk(clk),
		.arst_n(arst_n),
		.systime_set_en(systime_set_en),
		.systime_set(systime_set),
		.mcu_daq_data(mcu_daq_data),
		.mcu_daq_valid(mcu_daq_valid),
		.mcu_daq_end(mcu_daq_end),
		.mcu_daq_req(mcu_daq_req),
		.mcu_daq_grant(mcu_daq_grant),
		.daq_data(daq_data),
		.daq_valid(daq_valid),
		.daq_end(daq_end),
		.systime(systime),
		.leds(leds)
	);

	bind daq_arbiter conan_asserts u_conan_asserts (
		.clk(clk),
		.arst_n(arst_n),
		.syst_req(syst_daq.req),
		.syst_grant(syst_daq.grant),
		.syst_valid(syst_daq.valid),
		.mcu_req(mcu_daq.req),
		.mcu_grant(mcu_daq.grant),
		.mcu_valid(mcu_daq.valid),
		.owner(owner),
		.sy_state(tb_conan.dut.u_systime_notifier.sy_state),
		.leds(tb_conan.dut.leds)
	);

	// ------------------------------------------------------------------------
	// reference models
	// ------------------------------------------------------------------------
	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// header word in the upper half, raw lower time word in the lower half
	function automatic logic [63:0] time_msg_ref(input logic [7:0] daq_type,
		input logic [`CONAN_LATCH_BITS-1:0] latched);
		conan_pkg::daq_word_u hdr;
		conan_pkg::daq_word_u lower;
		hdr.hdr.daq_type = daq_type;
		hdr.hdr.stamp_hi = latched[55:32];
		lower.raw = latched[31:0];
		return {hdr.raw, lower.raw};
	endfunction

	function automatic logic [`CONAN_NLEDS-1:0] led_ref(input int rotations);
		logic [`CONAN_NLEDS-1:0] pattern;
		pattern = 1;
		pattern = pattern << (rotations % `CONAN_NLEDS);
		return pattern;
	endfunction

	task automatic rand64(output logic [63:0] r);
		rng = xorshift32(rng);
		r[63:32] = rng;
		rng = xorshift32(rng);
		r[31:0] = rng;
	endtask

	task automatic check_value(input string what, input logic [63:0] expected,
		input logic [63:0] actual);
		check_count++;
		assert (actual === expected) else begin
			err_count++;
			$display("ERROR %s: %s expected %h, actual %h", test_name, what, expected, actual);
		end
	endtask

	// ------------------------------------------------------------------------
	// stimulus helpers
	// ------------------------------------------------------------------------
	task automatic expect_time_msg(input logic [7:0] daq_type, input logic [63:0] stamp);
		logic [63:0] words;
		words = time_msg_ref(daq_type, stamp[`CONAN_LATCH_BITS-1:0]);
		exp_words.push_back(words[63:32]);
		exp_ends.push_back(1'b0);
		exp_words.push_back(words[31:0]);
		exp_ends.push_back(1'b1);
	endtask

	// systime takes the value at the second edge
	task automatic load_time(input logic [63:0] value);
		@(posedge clk);
		systime_set_en <= 1'b1;
		systime_set <= value;
		@(posedge clk);
		systime_set_en <= 1'b0;
	endtask

	task automatic wait_drain(input int max_cycles);
		int n;
		n = 0;
		while (exp_words.size() > 0 && n < max_cycles) begin
			@(negedge clk);
			n++;
		end
		assert (exp_words.size() == 0) else begin
			err_count++;
			$display("timeout: %0d expected words never came out in test %s",
				exp_words.size(), test_name);
			exp_words.delete();
			exp_ends.delete();
		end
	endtask

	task automatic send_mcu_msg(input int len);
		logic [`CONAN_DAQ_BITS-1:0] words[4];
		int n;
		logic granted;
		for (int i = 0; i < len; i++) begin
			rng = xorshift32(rng);
			words[i] = rng;
			exp_words.push_back(rng);
			exp_ends.push_back(i == len - 1);
		end
		@(posedge clk);
		mcu_daq_req <= 1'b1;
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (!mcu_daq_grant && n < 100);
		granted = mcu_daq_grant;
		assert (granted) else begin
			err_count++;
			$display("timeout: mcu request never granted in test %s", test_name);
		end
		@(posedge clk);
		mcu_daq_req <= 1'b0;
		if (!granted) begin
			exp_words.delete();
			exp_ends.delete();
			return;
		end
		// words start the cycle after the grant
		for (int i = 0; i < len; i++) begin
			mcu_daq_valid <= 1'b1;
			mcu_daq_data <= words[i];
			mcu_daq_end <= (i == len - 1);
			@(posedge clk);
		end
		mcu_daq_valid <= 1'b0;
		mcu_daq_end <= 1'b0;
	endtask

	// ------------------------------------------------------------------------
	// comparing process
	// ------------------------------------------------------------------------
	always @(negedge clk) begin : compare
		logic [`CONAN_DAQ_BITS-1:0] exp_word;
		logic exp_end;
		if (arst_n && daq_valid) begin
			check_count++;
			assert (exp_words.size() > 0) else begin
				err_count++;
				$display("unexpected word %h on daq_data in test %s", daq_data, test_name);
			end
			if (exp_words.size() > 0) begin
				exp_word = exp_words.pop_front();
				exp_end = exp_ends.pop_front();
				check_value("daq_data", exp_word, daq_data);
				check_value("daq_end", exp_end, daq_end);
			end
		end
	end

	// ------------------------------------------------------------------------
	// test sequence
	// ------------------------------------------------------------------------
	initial begin : stimulus
		logic [63:0] value;
		logic [63:0] boundary;
		int len;
		int n;
		int assert_fails;
		rng = 32'hff7e223d;
		// systime leaves reset at zero, so the first edge steps the leds
		rot_count = 1;
		test_name = "reset";
		systime_set_en = 1'b0;
		systime_set = '0;
		mcu_daq_data = '0;
		mcu_daq_valid = 1'b0;
		mcu_daq_end = 1'b0;
		mcu_daq_req = 1'b0;

		@(negedge clk);
		check_value("leds", 8'h01, leds);
		check_value("daq_valid", 1'b0, daq_valid);
		check_value("mcu_daq_grant", 1'b0, mcu_daq_grant);
		n = 0;
		while (!arst_n && n < 20) begin
			@(negedge clk);
			n++;
		end
		assert (arst_n) else begin
			err_count++;
			$display("reset was never released");
		end

		test_name = "count";
		value = systime;
		repeat (4) begin
			@(negedge clk);
			value = value + 1;
			check_value("systime", value, systime);
		end
		check_value("daq_valid", 1'b0, daq_valid);
		check_value("mcu_daq_grant", 1'b0, mcu_daq_grant);

		test_name = "load";
		repeat (3) begin
			rand64(value);
			// low bits kept far from the LED wrap and the rollover
			value[21:20] = 2'b01;
			expect_time_msg(`CONAN_DAQT_SYSTIME_SET, value);
			load_time(value);
			@(negedge clk);
			check_value("systime", value, systime);
			@(negedge clk);
			check_value("systime", value + 1, systime);
			wait_drain(50);
		end

		test_name = "rollover";
		rand64(boundary);
		boundary[25:0] = '0;
		value = boundary - 20;
		expect_time_msg(`CONAN_DAQT_SYSTIME_SET, value);
		expect_time_msg(`CONAN_DAQT_SYSTIME_ROLLOVER, boundary);
		load_time(value);
		wait_drain(100);
		// the boundary wraps the LED bits as well
		rot_count++;
		check_value("leds", led_ref(rot_count), leds);

		test_name = "leds";
		repeat (3) begin
			rand64(boundary);
			boundary[21:0] = '0;
			boundary[22] = 1'b1;
			value = boundary - 5;
			expect_time_msg(`CONAN_DAQT_SYSTIME_SET, value);
			load_time(value);
			n = 0;
			while (leds == led_ref(rot_count) && n < 50) begin
				@(negedge clk);
				n++;
			end
			rot_count++;
			check_value("leds", led_ref(rot_count), leds);
			wait_drain(50);
		end

		test_name = "mcu";
		repeat (4) begin
			rng = xorshift32(rng);
			len = int'(rng[1:0]) + 1;
			send_mcu_msg(len);
			wait_drain(50);
		end

		test_name = "priority";
		rand64(value);
		value[21:20] = 2'b01;
		rng = xorshift32(rng);
		len = int'(rng[1:0]) + 1;
		expect_time_msg(`CONAN_DAQT_SYSTIME_SET, value);
		load_time(value);
		// mcu req rises on the same edge as the notifier's req
		send_mcu_msg(len);
		wait_drain(50);

		// a few idle cycles to catch stray words
		repeat (4) @(negedge clk);
		assert_fails = dut.u_daq_arbiter.u_conan_asserts.fail_count;
		$display("checks: %0d, errors: %0d, assertion failures: %0d",
			check_count, err_count, assert_fails);
		if (err_count == 0 && assert_fails == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+source
source/conan_pkg.sv
source/daq_if.sv
source/time_base.sv
source/led_chaser.sv
source/systime_notifier.sv
source/daq_arbiter.sv
source/conan_top.sv
bench/tb_clk_gen.sv
bench/conan_asserts.sv
bench/tb_conan.sv

// ==== Bender.yml ====
package:
  name: conan

sources:
  - include_dirs:
      - source
    files:
      - source/conan_pkg.sv
      - source/daq_if.sv
      - source/time_base.sv
      - source/led_chaser.sv
      - source/systime_notifier.sv
      - source/daq_arbiter.sv
      - source/conan_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - bench/tb_clk_gen.sv
      - bench/conan_asserts.sv
      - bench/tb_conan.sv
